// File: Bender.yml
package:
  name: mmio_client

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mmioPkg.sv
      - source/shellRegFile.sv
      - source/mmioPageRam.sv
      - source/emifBusPort.sv
      - source/mmioClient.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/mmioClientTb.sv

// File: flist.f
+incdir+include
source/mmioPkg.sv
source/shellRegFile.sv
source/mmioPageRam.sv
source/emifBusPort.sv
source/mmioClient.sv
tb/mmioClientTb.sv

// File: include/mmio_defines.svh
// =========================================================================
// MMIO client definitions
// Byte bus geometry, register map offsets, reset values and RAM geometry
// =========================================================================

`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// =========================================================================
// Bus and RAM geometry
// =========================================================================
`define EMIF_AW             8       // Bus address width
`define EMIF_DW             8       // Bus data width
`define REG_AW              7       // Offset within one 128-byte page
`define PAGE_SEL_W          4       // Page bits seen by the RAM
`define RAM_AW              11      // Page number above page offset
`define RAM_BYTES           2048    // 16 pages of 128 bytes

// =========================================================================
// Register offsets in the lower half
// =========================================================================
// Product data, read only
`define ADDR_VPD_ID         7'h00
`define ADDR_VPD_VER        7'h01
`define ADDR_VPD_REV        7'h02
// Physical layer
`define ADDR_PHY_STAT       7'h10   // Live status
`define ADDR_PHY_CTRL       7'h11
// Layer 2
`define ADDR_LY2_CTRL       7'h20
`define ADDR_LY2_MAC0       7'h22   // MAC0..MAC5 at 22..27
// Layer 3
`define ADDR_LY3_CTRL0      7'h30
`define ADDR_LY3_IP0        7'h34   // IP0..IP3 at 34..37
// Diagnostics
`define ADDR_DIAG_SCRATCH0  7'h70   // Four scratch bytes
`define ADDR_DIAG_LOOPCTRL  7'h74
`define ADDR_DIAG_PAGE_SEL  7'h7F   // Upper window page

// =========================================================================
// Reset values, everything else clears to zero
// =========================================================================
`define DEF_VPD_ID          8'h3D   // Flash build with RAM window
`define DEF_VPD_VER         8'h01
`define DEF_VPD_REV         8'h00
`define DEF_PHY_CTRL        8'h01   // Rx equalizer in DFE mode

`endif

// File: source/emifBusPort.sv
// =========================================================================
// EMIF bus port
// Splits byte bus accesses into register file and RAM window strobes and
// returns the read byte with one cycle of latency
// =========================================================================

`timescale 1ns/10ps

`include "mmio_defines.svh"

module emifBusPort
(
  input  logic              shlClk,
  input  logic              rst,
  input  logic              csN,         // Chip select, active low
  input  logic              weN,         // Write enable, active low
  input  mmioPkg::emifAddrT addr,
  input  mmioPkg::emifDataT regRdData,   // Same cycle from register file
  input  mmioPkg::emifDataT ramRdData,   // One cycle late from RAM
  output logic              regWrEn,
  output logic              regRdEn,
  output logic              ramWrEn,
  output logic              ramRdEn,
  output mmioPkg::regAddrT  regAddr,
  output mmioPkg::regAddrT  ramOffset,
  output mmioPkg::emifDataT rdData
);

  import mmioPkg::*;

  logic     wrAccess;
  logic     rdAccess;
  logic     ramRegion;     // Address bit 7 picks the RAM window
  logic     rdFromRam;     // Region of the last read
  emifDataT regByteQ;      // Register byte captured at the request

  // =========================================================================
  // Region decode
  // =========================================================================
  assign wrAccess  = !csN && !weN;
  assign rdAccess  = !csN && weN;
  assign ramRegion = addr[`EMIF_AW-1];

  assign regWrEn   = wrAccess && !ramRegion;
  assign regRdEn   = rdAccess && !ramRegion;
  assign ramWrEn   = wrAccess && ramRegion;
  assign ramRdEn   = rdAccess && ramRegion;

  assign regAddr   = addr[`REG_AW-1:0];
  assign ramOffset = addr[`REG_AW-1:0];   // Page number comes from the reg file

  // =========================================================================
  // Read return
  // =========================================================================
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      rdFromRam <= 1'b0;
      regByteQ  <= '0;
    end
    else if (rdAccess)
    begin
      rdFromRam <= ramRegion;
      if (!ramRegion)
        regByteQ <= regRdData;
    end
  end

  // RAM byte arrives registered and passes straight through
  assign rdData = rdFromRam ? ramRdData : regByteQ;

  // Host must drive the strobes once out of reset
  strobeKnownA: assert property (@(posedge shlClk) disable iff (rst)
    !$isunknown({csN, weN}));

endmodule

// File: source/mmioClient.sv
// =========================================================================
// MMIO client top
// Byte bus client for the network shell. Lower half is the register
// file, upper half is the paged RAM window
// =========================================================================

`timescale 1ns/10ps

module mmioClient
(
  input  logic              shlClk,               // Shell clock
  input  logic              rst,
  // Host byte bus
  input  logic              csN,
  input  logic              weN,
  input  mmioPkg::emifAddrT addr,
  input  mmioPkg::emifDataT wrData,
  output mmioPkg::emifDataT rdData,
  // Memory and Ethernet status
  input  logic              mc0InitCalComplete,
  input  logic              mc1InitCalComplete,
  input  logic              eth0CoreReady,
  input  logic              eth0QpllLock,
  // Shell controls
  output logic              rxEqualizerMode,
  output logic              pcsLoopbackEn,
  output logic              macLoopbackEn,
  output mmioPkg::macAddrT  macAddress,
  output mmioPkg::ipAddrT   ipAddress
);

  import mmioPkg::*;

  // =========================================================================
  // Internal wiring
  // =========================================================================
  logic     regWrEn;
  logic     regRdEn;
  logic     ramWrEn;
  logic     ramRdEn;
  regAddrT  regAddr;
  regAddrT  ramOffset;
  emifDataT regRdData;
  emifDataT ramRdData;
  pageSelT  pageSel;

  emifBusPort busPort_i
  (
    .shlClk    (shlClk),
    .rst       (rst),
    .csN       (csN),
    .weN       (weN),
    .addr      (addr),
    .regRdData (regRdData),
    .ramRdData (ramRdData),
    .regWrEn   (regWrEn),
    .regRdEn   (regRdEn),
    .ramWrEn   (ramWrEn),
    .ramRdEn   (ramRdEn),
    .regAddr   (regAddr),
    .ramOffset (ramOffset),
    .rdData    (rdData)
  );

  shellRegFile regFile_i
  (
    .shlClk             (shlClk),
    .rst                (rst),
    .wrEn               (regWrEn),
    .rdEn               (regRdEn),
    .mc0InitCalComplete (mc0InitCalComplete),
    .mc1InitCalComplete (mc1InitCalComplete),
    .eth0CoreReady      (eth0CoreReady),
    .eth0QpllLock       (eth0QpllLock),
    .regAddr            (regAddr),
    .wrData             (wrData),
    .rdData             (regRdData),
    .pageSel            (pageSel),
    .rxEqualizerMode    (rxEqualizerMode),
    .pcsLoopbackEn      (pcsLoopbackEn),
    .macLoopbackEn      (macLoopbackEn),
    .macAddress         (macAddress),
    .ipAddress          (ipAddress)
  );

  mmioPageRam pageRam_i
  (
    .shlClk  (shlClk),
    .wrEn    (ramWrEn),
    .rdEn    (ramRdEn),
    .pageSel (pageSel),
    .offset  (ramOffset),
    .wrData  (wrData),
    .rdData  (ramRdData)
  );

endmodule

// File: source/mmioPageRam.sv
// =========================================================================
// Paged RAM window
// 2 KB single-port byte RAM seen through the upper half of the bus,
// one 128-byte page at a time
// =========================================================================

`timescale 1ns/10ps

`include "mmio_defines.svh"

module mmioPageRam
(
  input  logic              shlClk,
  input  logic              wrEn,
  input  logic              rdEn,
  input  mmioPkg::pageSelT  pageSel,   // From the page-select register
  input  mmioPkg::regAddrT  offset,    // Byte within the page
  input  mmioPkg::emifDataT wrData,
  output mmioPkg::emifDataT rdData     // Valid one cycle after rdEn
);

  import mmioPkg::*;

  emifDataT mem [`RAM_BYTES];
  ramAddrT  ramAddr;

  // Page number on top, page offset below
  assign ramAddr = {pageSel, offset};

  // =========================================================================
  // Write port
  // =========================================================================
  always_ff @(posedge shlClk)
  begin
    if (wrEn)
      mem[ramAddr] <= wrData;
  end

  // =========================================================================
  // Read port, output held until next read
  // =========================================================================
  always_ff @(posedge shlClk)
  begin
    if (rdEn)
      rdData <= mem[ramAddr];
  end

  // A request is a read or a write, never both
  rdWrExclA: assert property (@(posedge shlClk)
    rdEn |-> !wrEn);

endmodule

// File: source/mmioPkg.sv
// =========================================================================
// MMIO client types
// Vector types for bus fields, register offsets and shell addresses
// =========================================================================

`include "mmio_defines.svh"

package mmioPkg;

  // Byte bus fields
  typedef logic [`EMIF_AW-1:0]    emifAddrT;  // Full bus address
  typedef logic [`EMIF_DW-1:0]    emifDataT;  // One data byte

  // Offset inside the lower half or inside one RAM page
  typedef logic [`REG_AW-1:0]     regAddrT;

  // Paged RAM addressing
  typedef logic [`PAGE_SEL_W-1:0] pageSelT;   // Page number
  typedef logic [`RAM_AW-1:0]     ramAddrT;   // Page above offset

  // Network identity driven to the shell
  typedef logic [6*`EMIF_DW-1:0]  macAddrT;   // MAC0 in the top byte
  typedef logic [4*`EMIF_DW-1:0]  ipAddrT;    // IP0 in the top byte

endpackage

// File: source/shellRegFile.sv
// =========================================================================
// Shell register file
// 128-byte control and status map of the MMIO client. Product data and
// status read back live while control bytes drive the shell outputs
// =========================================================================

`timescale 1ns/10ps

`include "mmio_defines.svh"

module shellRegFile
(
  input  logic              shlClk,
  input  logic              rst,
  input  logic              wrEn,                // Write strobe, lower half
  input  logic              rdEn,                // Read strobe, lower half
  input  logic              mc0InitCalComplete,
  input  logic              mc1InitCalComplete,
  input  logic              eth0CoreReady,
  input  logic              eth0QpllLock,
  input  mmioPkg::regAddrT  regAddr,
  input  mmioPkg::emifDataT wrData,
  output mmioPkg::emifDataT rdData,              // Combinational read
  output mmioPkg::pageSelT  pageSel,             // To the RAM window
  output logic              rxEqualizerMode,
  output logic              pcsLoopbackEn,
  output logic              macLoopbackEn,
  output mmioPkg::macAddrT  macAddress,
  output mmioPkg::ipAddrT   ipAddress
);

  import mmioPkg::*;

  // =========================================================================
  // Storage
  // =========================================================================
  emifDataT   phyCtrl;
  emifDataT   ly2Ctrl;
  emifDataT   macByte [6];     // MAC0 first
  emifDataT   ly3Ctrl0;
  emifDataT   ipByte [4];      // IP0 first
  emifDataT   scratch [4];
  emifDataT   loopCtrl;
  emifDataT   pageSelReg;      // RAM sees only the low bits
  emifDataT   phyStat;         // Live status from the inputs

  // Index inside the multi-byte fields
  logic [2:0] macIdx;
  logic [1:0] ipIdx;
  logic [1:0] scrIdx;

  assign macIdx = 3'(regAddr - `ADDR_LY2_MAC0);
  assign ipIdx  = 2'(regAddr - `ADDR_LY3_IP0);
  assign scrIdx = 2'(regAddr - `ADDR_DIAG_SCRATCH0);

  // Status overlay with a zero upper nibble
  assign phyStat = {4'b0000, eth0QpllLock, eth0CoreReady,
                    mc1InitCalComplete, mc0InitCalComplete};

  // =========================================================================
  // Writes to the control bytes
  // =========================================================================
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      phyCtrl    <= `DEF_PHY_CTRL;
      ly2Ctrl    <= '0;
      ly3Ctrl0   <= '0;
      loopCtrl   <= '0;
      pageSelReg <= '0;
      for (int i = 0; i < 6; i++)
        macByte[i] <= '0;
      for (int i = 0; i < 4; i++)
      begin
        ipByte[i]  <= '0;
        scratch[i] <= '0;
      end
    end
    else if (wrEn)
    begin
      case (regAddr) inside
        `ADDR_PHY_CTRL:      phyCtrl    <= wrData;
        `ADDR_LY2_CTRL:      ly2Ctrl    <= wrData;
        [`ADDR_LY2_MAC0 : `ADDR_LY2_MAC0 + 7'd5]:
          macByte[macIdx] <= wrData;
        `ADDR_LY3_CTRL0:     ly3Ctrl0   <= wrData;
        [`ADDR_LY3_IP0 : `ADDR_LY3_IP0 + 7'd3]:
          ipByte[ipIdx] <= wrData;
        [`ADDR_DIAG_SCRATCH0 : `ADDR_DIAG_SCRATCH0 + 7'd3]:
          scratch[scrIdx] <= wrData;
        `ADDR_DIAG_LOOPCTRL: loopCtrl   <= wrData;
        `ADDR_DIAG_PAGE_SEL: pageSelReg <= wrData;
        default: ;                       // Read-only or reserved
      endcase
    end
  end

  // =========================================================================
  // Read mux
  // =========================================================================
  always_comb
  begin
    case (regAddr) inside
      `ADDR_VPD_ID:        rdData = `DEF_VPD_ID;
      `ADDR_VPD_VER:       rdData = `DEF_VPD_VER;
      `ADDR_VPD_REV:       rdData = `DEF_VPD_REV;
      `ADDR_PHY_STAT:      rdData = phyStat;
      `ADDR_PHY_CTRL:      rdData = phyCtrl;
      `ADDR_LY2_CTRL:      rdData = ly2Ctrl;
      [`ADDR_LY2_MAC0 : `ADDR_LY2_MAC0 + 7'd5]:
        rdData = macByte[macIdx];
      `ADDR_LY3_CTRL0:     rdData = ly3Ctrl0;
      [`ADDR_LY3_IP0 : `ADDR_LY3_IP0 + 7'd3]:
        rdData = ipByte[ipIdx];
      [`ADDR_DIAG_SCRATCH0 : `ADDR_DIAG_SCRATCH0 + 7'd3]:
        rdData = scratch[scrIdx];
      `ADDR_DIAG_LOOPCTRL: rdData = loopCtrl;
      `ADDR_DIAG_PAGE_SEL: rdData = pageSelReg;
      default:             rdData = '0;   // Reserved
    endcase
  end

  // =========================================================================
  // Shell controls
  // =========================================================================
  assign rxEqualizerMode = phyCtrl[0];
  assign pcsLoopbackEn   = loopCtrl[0];
  assign macLoopbackEn   = loopCtrl[1];
  assign pageSel         = pageSelReg[`PAGE_SEL_W-1:0];
  assign macAddress      = {macByte[0], macByte[1], macByte[2],
                            macByte[3], macByte[4], macByte[5]};
  assign ipAddress       = {ipByte[0], ipByte[1], ipByte[2], ipByte[3]};

  // Bus port issues one access per cycle
  rdWrExclA: assert property (@(posedge shlClk) disable iff (rst)
    rdEn |-> !wrEn);

endmodule

// File: tb/mmioClientTb.sv
// =========================================================================
// MMIO client testbench
// Random byte bus traffic on the register file and paged RAM window,
// checked against a register and RAM model
// =========================================================================

`timescale 1ns/10ps

`include "mmio_defines.svh"

module mmioClientTb;

  import mmioPkg::*;

  logic     shlClk;
  logic     rst;
  logic     csN;
  logic     weN;
  emifAddrT addr;
  emifDataT wrData;
  emifDataT rdData;
  logic     mc0InitCalComplete;
  logic     mc1InitCalComplete;
  logic     eth0CoreReady;
  logic     eth0QpllLock;
  logic     rxEqualizerMode;
  logic     pcsLoopbackEn;
  logic     macLoopbackEn;
  macAddrT  macAddress;
  ipAddrT   ipAddress;

  // =========================================================================
  // Model state
  // =========================================================================
  emifDataT   regModel [128];          // Lower half as the host sees it
  emifDataT   ramModel [`RAM_BYTES];   // Page above offset
  regAddrT    writableQ [$];           // Offsets that accept data
  logic [3:0] statusModel;             // Nibble driven onto the status inputs
  integer     seed;
  int         errorCount;
  int         timeoutCount;

  mmioClient dut_i
  (
    .shlClk             (shlClk),
    .rst                (rst),
    .csN                (csN),
    .weN                (weN),
    .addr               (addr),
    .wrData             (wrData),
    .rdData             (rdData),
    .mc0InitCalComplete (mc0InitCalComplete),
    .mc1InitCalComplete (mc1InitCalComplete),
    .eth0CoreReady      (eth0CoreReady),
    .eth0QpllLock       (eth0QpllLock),
    .rxEqualizerMode    (rxEqualizerMode),
    .pcsLoopbackEn      (pcsLoopbackEn),
    .macLoopbackEn      (macLoopbackEn),
    .macAddress         (macAddress),
    .ipAddress          (ipAddress)
  );

  initial shlClk = 1'b0;
  always #2 shlClk = ~shlClk;        // 4 ns period

  initial
  begin
    rst = 1'b1;
    repeat (5) @(posedge shlClk);
    @(negedge shlClk);
    rst = 1'b0;
  end

  // =========================================================================
  // Register map rules
  // =========================================================================
  function automatic logic isWritable(input regAddrT off);
    return (off == `ADDR_PHY_CTRL) || (off == `ADDR_LY2_CTRL) ||
           (off >= `ADDR_LY2_MAC0 && off <= `ADDR_LY2_MAC0 + 7'd5) ||
           (off == `ADDR_LY3_CTRL0) ||
           (off >= `ADDR_LY3_IP0 && off <= `ADDR_LY3_IP0 + 7'd3) ||
           (off >= `ADDR_DIAG_SCRATCH0 && off <= `ADDR_DIAG_SCRATCH0 + 7'd3) ||
           (off == `ADDR_DIAG_LOOPCTRL) || (off == `ADDR_DIAG_PAGE_SEL);
  endfunction

  function automatic emifDataT expectedByte(input emifAddrT a);
    regAddrT  off;
    emifDataT v;
    off = a[6:0];
    if (a[7])
      v = ramModel[{regModel[`ADDR_DIAG_PAGE_SEL][3:0], off}];   // Low page bits only
    else if (off == `ADDR_VPD_ID)
      v = `DEF_VPD_ID;
    else if (off == `ADDR_VPD_VER)
      v = `DEF_VPD_VER;
    else if (off == `ADDR_VPD_REV)
      v = `DEF_VPD_REV;
    else if (off == `ADDR_PHY_STAT)
      v = {4'h0, statusModel};
    else if (isWritable(off))
      v = regModel[off];
    else
      v = 8'h00;                     // Reserved
    return v;
  endfunction

  // Depends on every RAM address bit
  function automatic emifDataT fillByte(input int idx);
    return 8'(idx) ^ 8'(idx >> 3);
  endfunction

  // =========================================================================
  // Bus tasks enter and leave on a falling edge
  // =========================================================================
  task automatic checkControls();
    macAddrT expMac;
    ipAddrT  expIp;
    expMac = '0;
    expIp  = '0;
    for (int k = 0; k < 6; k++)
      expMac = {expMac[39:0], regModel[`ADDR_LY2_MAC0 + k]};   // MAC0 ends on top
    for (int k = 0; k < 4; k++)
      expIp = {expIp[23:0], regModel[`ADDR_LY3_IP0 + k]};
    if (macAddress !== expMac)
    begin
      $display("[FAIL] %0t ns: macAddress 0x%012h, expected 0x%012h", $time, macAddress, expMac);
      errorCount++;
    end
    if (ipAddress !== expIp)
    begin
      $display("[FAIL] %0t ns: ipAddress 0x%08h, expected 0x%08h", $time, ipAddress, expIp);
      errorCount++;
    end
    if (rxEqualizerMode !== regModel[`ADDR_PHY_CTRL][0])
    begin
      $display("[FAIL] %0t ns: rxEqualizerMode is %b", $time, rxEqualizerMode);
      errorCount++;
    end
    if ({macLoopbackEn, pcsLoopbackEn} !== regModel[`ADDR_DIAG_LOOPCTRL][1:0])
    begin
      $display("[FAIL] %0t ns: loopback enables mac %b pcs %b", $time,
               macLoopbackEn, pcsLoopbackEn);
      errorCount++;
    end
  endtask

  task automatic writeByte(input emifAddrT a, input emifDataT d);
    csN    = 1'b0;
    weN    = 1'b0;
    addr   = a;
    wrData = d;
    @(posedge shlClk);
    @(negedge shlClk);
    csN = 1'b1;
    weN = 1'b1;
    if (a[7])
      ramModel[{regModel[`ADDR_DIAG_PAGE_SEL][3:0], a[6:0]}] = d;
    else if (isWritable(a[6:0]))
      regModel[a[6:0]] = d;
    checkControls();                 // Outputs move on the write edge
  endtask

  // Leaves the bus driven so a following read pipelines behind it
  task automatic issueRead(input emifAddrT a);
    emifDataT expected;
    expected = expectedByte(a);
    csN  = 1'b0;
    weN  = 1'b1;
    addr = a;
    @(posedge shlClk);               // Request edge
    @(negedge shlClk);
    if (rdData !== expected)
    begin
      $display("[FAIL] %0t ns: read of 0x%02h returned 0x%02h, expected 0x%02h",
               $time, a, rdData, expected);
      errorCount++;
    end
  endtask

  task automatic readCheck(input emifAddrT a);
    issueRead(a);
    csN = 1'b1;
  endtask

  task automatic waitForReset(output logic released);
    int cycles;
    cycles = 0;
    while (rst && cycles < 50)
    begin
      @(negedge shlClk);
      cycles++;
    end
    released = !rst;
  endtask

  // =========================================================================
  // Main sequence
  // =========================================================================
  initial
  begin
    logic     released;
    regAddrT  off;
    emifDataT d;
    emifDataT pageByte;
    int       pick;
    seed               = 32'h436b;
    errorCount         = 0;
    timeoutCount       = 0;
    csN                = 1'b1;
    weN                = 1'b1;
    addr               = '0;
    wrData             = '0;
    mc0InitCalComplete = 1'b0;
    mc1InitCalComplete = 1'b0;
    eth0CoreReady      = 1'b0;
    eth0QpllLock       = 1'b0;
    for (int i = 0; i < 128; i++)
    begin
      regModel[i] = 8'h00;
      if (isWritable(7'(i)))
        writableQ.push_back(7'(i));
    end
    regModel[`ADDR_PHY_CTRL] = `DEF_PHY_CTRL;
    statusModel = 4'($random(seed));
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = statusModel;

    @(negedge shlClk);
    waitForReset(released);
    if (!released)
    begin
      $display("Error: reset was still asserted after 50 clock cycles");
      timeoutCount++;
    end
    else
    begin
      // Reset defaults over the whole lower half
      if (rdData !== 8'h00)
      begin
        $display("[FAIL] %0t ns: rdData 0x%02h after reset, expected 0x00", $time, rdData);
        errorCount++;
      end
      checkControls();
      for (int i = 0; i < 128; i++)
        readCheck({1'b0, 7'(i)});

      // Writable registers, writes mixed with reads
      for (int i = 0; i < 300; i++)
      begin
        off = writableQ[$unsigned($random(seed)) % writableQ.size()];
        if ($random(seed) & 1)
          writeByte({1'b0, off}, 8'($random(seed)));
        else
          readCheck({1'b0, off});
      end

      // Protected offsets ignore writes
      writeByte({1'b0, `ADDR_VPD_ID}, 8'hA5);
      readCheck({1'b0, `ADDR_VPD_ID});
      writeByte({1'b0, `ADDR_VPD_VER}, 8'h5A);
      readCheck({1'b0, `ADDR_VPD_VER});
      writeByte({1'b0, `ADDR_VPD_REV}, 8'hFF);
      readCheck({1'b0, `ADDR_VPD_REV});
      writeByte({1'b0, `ADDR_PHY_STAT}, 8'hF0);
      readCheck({1'b0, `ADDR_PHY_STAT});
      for (int i = 0; i < 128; i++)
      begin
        off = 7'($random(seed));
        if (!isWritable(off))
        begin
          writeByte({1'b0, off}, 8'($random(seed)));
          readCheck({1'b0, off});
        end
      end

      // Status inputs in the low nibble
      for (int i = 0; i < 24; i++)
      begin
        statusModel = 4'($random(seed));
        {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} =
          statusModel;
        readCheck({1'b0, `ADDR_PHY_STAT});
      end

      // =====================================================================
      // Paged RAM
      // =====================================================================
      for (int p = 0; p < 16; p++)
      begin
        writeByte({1'b0, `ADDR_DIAG_PAGE_SEL}, 8'(p));
        for (int o = 0; o < 128; o++)
          writeByte({1'b1, 7'(o)}, fillByte(p * 128 + o));
      end
      for (int i = 0; i < 400; i++)
      begin
        pick = $unsigned($random(seed)) % 4;
        if (pick == 0)
          writeByte({1'b0, `ADDR_DIAG_PAGE_SEL}, 8'($random(seed)));
        else if (pick == 1)
          writeByte({1'b1, 7'($random(seed))}, 8'($random(seed)));
        else
          readCheck({1'b1, 7'($random(seed))});
      end

      // Upper page-select bits do not reach the RAM
      for (int i = 0; i < 8; i++)
      begin
        pageByte = 8'($random(seed));
        off      = 7'($random(seed));
        d        = 8'($random(seed));
        writeByte({1'b0, `ADDR_DIAG_PAGE_SEL}, pageByte);
        writeByte({1'b1, off}, d);
        writeByte({1'b0, `ADDR_DIAG_PAGE_SEL}, pageByte ^ {4'($random(seed)) | 4'h1, 4'h0});
        readCheck({1'b1, off});
        readCheck({1'b0, `ADDR_DIAG_PAGE_SEL});   // All 8 bits kept
      end

      // Back-to-back reads alternating register and RAM
      for (int i = 0; i < 64; i++)
        issueRead({i[0], 7'($random(seed))});
      csN = 1'b1;
    end

    $display("Run complete: %0d value errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
